// ==== source/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and address word width
`define CPU_WORD_SIZE 16

// General purpose registers
`define CPU_REG_COUNT 4

// Unified memory words, addresses wrap
`define CPU_MEM_DEPTH 256

`endif

// ==== source/cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_SIZE-1:0]         word_t;
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;
    typedef logic [$clog2(`CPU_MEM_DEPTH)-1:0] mem_addr_t;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_t;

    // EX operand source
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    // Instruction fields
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int RS_MSB     = 11;
    localparam int RS_LSB     = 10;
    localparam int RT_MSB     = 9;
    localparam int RT_LSB     = 8;
    localparam int RD_MSB     = 7;
    localparam int RD_LSB     = 6;
    localparam int FUNC_MSB   = 5;
    localparam int FUNC_LSB   = 0;
    localparam int IMM_MSB    = 7;
    localparam int IMM_LSB    = 0;

endpackage

// ==== source/control_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module control_decoder
    import cpu_pkg::*;
(
    input  opcode_t opcode,
    input  func_t   func,
    output alu_op_t alu_op,
    output logic    alu_src_imm,
    output logic    mem_read,
    output logic    mem_write,
    output logic    reg_write,
    output logic    dest_is_rt,
    output logic    is_branch,
    output logic    branch_on_equal,
    output logic    is_jump,
    output logic    is_wwd,
    output logic    is_halt,
    output logic    uses_rt
);

    always_comb begin
        // No-op unless the encoding is known
        alu_op          = ALU_ADD;
        alu_src_imm     = 1'b0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        reg_write       = 1'b0;
        dest_is_rt      = 1'b0;
        is_branch       = 1'b0;
        branch_on_equal = 1'b0;
        is_jump         = 1'b0;
        is_wwd          = 1'b0;
        is_halt         = 1'b0;
        uses_rt         = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                case (func)
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_ORR:  alu_op = ALU_OR;
                    default: alu_op = ALU_ADD;
                endcase
                reg_write = func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR};
                uses_rt   = reg_write;
                is_wwd    = (func == FN_WWD);
                is_halt   = (func == FN_HLT);
            end
            OP_ADI: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                dest_is_rt  = 1'b1;
            end
            OP_LWD: begin
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
                reg_write   = 1'b1;
                dest_is_rt  = 1'b1;
            end
            OP_SWD: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                uses_rt     = 1'b1;
            end
            OP_BNE, OP_BEQ: begin
                is_branch       = 1'b1;
                uses_rt         = 1'b1;
                branch_on_equal = (opcode == OP_BEQ);
            end
            OP_JMP:  is_jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module register_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t read_addr1,
    input  reg_idx_t read_addr2,
    output word_t    read_data1,
    output word_t    read_data2,
    input  logic     write_en,
    input  reg_idx_t write_addr,
    input  word_t    write_data
);

    word_t regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // Same-cycle write is visible to ID
    assign read_data1 = (write_en && write_addr == read_addr1) ? write_data : regs[read_addr1];
    assign read_data2 = (write_en && write_addr == read_addr2) ? write_data : regs[read_addr2];

    assert property (@(posedge clk) disable iff (reset_n)
        write_en |-> !$isunknown(write_addr));

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module hazard_unit
    import cpu_pkg::*;
(
    input  reg_idx_t id_rs,
    input  reg_idx_t id_rt,
    input  logic     id_uses_rt,
    input  logic     id_is_branch,
    input  reg_idx_t ex_rd,
    input  logic     ex_reg_write,
    input  logic     ex_mem_read,
    input  reg_idx_t mem_rd,
    input  logic     mem_reg_write,
    input  reg_idx_t wb_rd,
    input  logic     wb_reg_write,
    input  reg_idx_t ex_rs,
    input  reg_idx_t ex_rt,
    output logic     stall,
    output fwd_sel_t forward_a,
    output fwd_sel_t forward_b
);

    logic ex_hit;
    logic mem_hit;

    function automatic fwd_sel_t newest_producer(reg_idx_t src);
        if (mem_reg_write && mem_rd == src) begin
            return FWD_MEM;
        end
        if (wb_reg_write && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    // ID operand still being produced further down
    assign ex_hit  = ex_reg_write && (ex_rd == id_rs || (id_uses_rt && ex_rd == id_rt));
    assign mem_hit = mem_reg_write && (mem_rd == id_rs || (id_uses_rt && mem_rd == id_rt));

    // Branches compare in ID, so they wait for the value to reach WB
    assign stall = (ex_mem_read && ex_hit) || (id_is_branch && (ex_hit || mem_hit));

    always_comb begin
        forward_a = newest_producer(ex_rs);
        forward_b = newest_producer(ex_rt);
    end

endmodule

// ==== source/pipeline_core.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module pipeline_core
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    output word_t fetch_addr,
    input  word_t fetch_inst,
    input  logic  fetch_grant,
    output logic  data_req,
    output logic  data_write,
    output word_t data_addr,
    output word_t data_wdata,
    input  word_t data_rdata,
    output word_t output_port,
    output logic  output_valid,
    output word_t num_inst,
    output logic  is_halted
);

    // IF/ID
    word_t    pc;
    word_t    if_pc;
    word_t    if_inst;
    logic     if_valid;

    // ID
    alu_op_t  dec_alu_op;
    logic     dec_alu_src_imm;
    logic     dec_mem_read;
    logic     dec_mem_write;
    logic     dec_reg_write;
    logic     dec_dest_is_rt;
    logic     dec_is_branch;
    logic     dec_branch_on_equal;
    logic     dec_is_jump;
    logic     dec_is_wwd;
    logic     dec_is_halt;
    logic     dec_uses_rt;
    reg_idx_t id_rs;
    reg_idx_t id_rt;
    reg_idx_t id_dest;
    word_t    id_a;
    word_t    id_b;
    word_t    id_imm;
    word_t    id_next_pc;
    word_t    id_target;
    logic     hz_stall;
    logic     stall;
    logic     taken;
    logic     id_go;
    logic     freeze;

    // ID/EX
    logic     ex_valid;
    logic     ex_reg_write;
    logic     ex_load;
    logic     ex_store;
    logic     ex_is_wwd;
    logic     ex_is_halt;
    alu_op_t  ex_alu_op;
    logic     ex_alu_src_imm;
    reg_idx_t ex_rs;
    reg_idx_t ex_rt;
    reg_idx_t ex_dest;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_imm;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_b;
    word_t    alu_out;
    word_t    ex_result;

    // EX/MEM
    logic     mem_valid;
    logic     mem_reg_write;
    logic     mem_load;
    logic     mem_store;
    logic     mem_is_wwd;
    logic     mem_is_halt;
    reg_idx_t mem_dest;
    word_t    mem_result;
    word_t    mem_store_data;

    // MEM/WB
    logic     wb_valid;
    logic     wb_reg_write;
    logic     wb_is_wwd;
    logic     wb_is_halt;
    reg_idx_t wb_dest;
    word_t    wb_data;

    ////////////////////
    // Decode and branch
    ////////////////////

    control_decoder i_decoder (
        .opcode          (opcode_t'(if_inst[OPCODE_MSB:OPCODE_LSB])),
        .func            (func_t'(if_inst[FUNC_MSB:FUNC_LSB])),
        .alu_op          (dec_alu_op),
        .alu_src_imm     (dec_alu_src_imm),
        .mem_read        (dec_mem_read),
        .mem_write       (dec_mem_write),
        .reg_write       (dec_reg_write),
        .dest_is_rt      (dec_dest_is_rt),
        .is_branch       (dec_is_branch),
        .branch_on_equal (dec_branch_on_equal),
        .is_jump         (dec_is_jump),
        .is_wwd          (dec_is_wwd),
        .is_halt         (dec_is_halt),
        .uses_rt         (dec_uses_rt)
    );

    register_file i_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .read_addr1 (id_rs),
        .read_addr2 (id_rt),
        .read_data1 (id_a),
        .read_data2 (id_b),
        .write_en   (wb_reg_write),
        .write_addr (wb_dest),
        .write_data (wb_data)
    );

    hazard_unit i_hazard (
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .id_uses_rt    (dec_uses_rt),
        .id_is_branch  (dec_is_branch),
        .ex_rd         (ex_dest),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_load),
        .mem_rd        (mem_dest),
        .mem_reg_write (mem_reg_write),
        .wb_rd         (wb_dest),
        .wb_reg_write  (wb_reg_write),
        .ex_rs         (ex_rs),
        .ex_rt         (ex_rt),
        .stall         (hz_stall),
        .forward_a     (fwd_a),
        .forward_b     (fwd_b)
    );

    assign id_rs      = if_inst[RS_MSB:RS_LSB];
    assign id_rt      = if_inst[RT_MSB:RT_LSB];
    assign id_dest    = dec_dest_is_rt ? id_rt : if_inst[RD_MSB:RD_LSB];
    assign id_imm     = {{(`CPU_WORD_SIZE-IMM_MSB-1){if_inst[IMM_MSB]}}, if_inst[IMM_MSB:IMM_LSB]};
    assign id_next_pc = if_pc + 1'b1;
    assign id_target  = dec_is_jump ? {id_next_pc[`CPU_WORD_SIZE-1:OPCODE_LSB], if_inst[RS_MSB:0]}
                                    : id_next_pc + id_imm;

    assign stall  = if_valid && hz_stall;
    assign id_go  = if_valid && !stall;
    assign taken  = id_go && (dec_is_jump ||
                    (dec_is_branch && ((id_a == id_b) == dec_branch_on_equal)));
    // HLT in WB stops everything on the same edge
    assign freeze = is_halted || (wb_valid && wb_is_halt);

    ////////////////////
    // Execute
    ////////////////////

    assign op_a = (fwd_a == FWD_MEM) ? mem_result : (fwd_a == FWD_WB) ? wb_data : ex_a;
    assign op_b = (fwd_b == FWD_MEM) ? mem_result : (fwd_b == FWD_WB) ? wb_data : ex_b;
    assign alu_b = ex_alu_src_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_out = op_a + alu_b;
            ALU_SUB: alu_out = op_a - alu_b;
            ALU_AND: alu_out = op_a & alu_b;
            default: alu_out = op_a | alu_b;
        endcase
    end

    // WWD carries its source operand down to WB
    assign ex_result = ex_is_wwd ? op_a : alu_out;

    ////////////////////
    // Pipeline registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc            <= '0;
            if_valid      <= 1'b0;
            ex_valid      <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_load       <= 1'b0;
            ex_store      <= 1'b0;
            ex_is_wwd     <= 1'b0;
            ex_is_halt    <= 1'b0;
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_load      <= 1'b0;
            mem_store     <= 1'b0;
            mem_is_wwd    <= 1'b0;
            mem_is_halt   <= 1'b0;
            wb_valid      <= 1'b0;
            wb_reg_write  <= 1'b0;
            wb_is_wwd     <= 1'b0;
            wb_is_halt    <= 1'b0;
        end else if (!freeze) begin
            if (!stall) begin
                if (taken) begin
                    pc <= id_target;
                end else if (fetch_grant) begin
                    pc <= pc + 1'b1;
                end
                // Wrong-path fetch or lost fetch slot becomes a bubble
                if_valid <= fetch_grant && !taken;
            end
            ex_valid      <= id_go;
            ex_reg_write  <= id_go && dec_reg_write;
            ex_load       <= id_go && dec_mem_read;
            ex_store      <= id_go && dec_mem_write;
            ex_is_wwd     <= id_go && dec_is_wwd;
            ex_is_halt    <= id_go && dec_is_halt;
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_reg_write;
            mem_load      <= ex_load;
            mem_store     <= ex_store;
            mem_is_wwd    <= ex_is_wwd;
            mem_is_halt   <= ex_is_halt;
            wb_valid      <= mem_valid;
            wb_reg_write  <= mem_reg_write;
            wb_is_wwd     <= mem_is_wwd;
            wb_is_halt    <= mem_is_halt;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            if (!stall && !taken && fetch_grant) begin
                if_inst <= fetch_inst;
                if_pc   <= pc;
            end
            ex_alu_op      <= dec_alu_op;
            ex_alu_src_imm <= dec_alu_src_imm;
            ex_rs          <= id_rs;
            ex_rt          <= id_rt;
            ex_dest        <= id_dest;
            ex_a           <= id_a;
            ex_b           <= id_b;
            ex_imm         <= id_imm;
            mem_dest       <= ex_dest;
            mem_result     <= ex_result;
            mem_store_data <= op_b;
            wb_dest        <= mem_dest;
            wb_data        <= mem_load ? data_rdata : mem_result;
        end
    end

    // Retire count and halt
    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst  <= '0;
            is_halted <= 1'b0;
        end else if (!is_halted && wb_valid) begin
            num_inst <= num_inst + 1'b1;
            if (wb_is_halt) begin
                is_halted <= 1'b1;
            end
        end
    end

    assign fetch_addr   = pc;
    assign data_req     = (mem_load || mem_store) && !freeze;
    assign data_write   = mem_store;
    assign data_addr    = mem_result;
    assign data_wdata   = mem_store_data;
    assign output_valid = wb_is_wwd;
    assign output_port  = output_valid ? wb_data : '0;

    assert property (@(posedge clk) disable iff (reset_n)
        !(output_valid && is_halted));

endmodule

// ==== source/arbitrated_memory.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module arbitrated_memory
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      load_en,
    input  mem_addr_t load_addr,
    input  word_t     load_data,
    input  logic      data_req,
    input  logic      data_write,
    input  word_t     data_addr,
    input  word_t     data_wdata,
    output word_t     data_rdata,
    input  word_t     fetch_addr,
    output word_t     fetch_inst,
    output logic      fetch_grant
);

    word_t     mem [`CPU_MEM_DEPTH];
    logic      data_grant;
    mem_addr_t data_index;
    mem_addr_t fetch_index;

    // Fixed priority: loader, data, fetch
    assign data_grant  = data_req && !load_en;
    assign fetch_grant = !load_en && !data_req;

    // Addresses wrap to the array depth
    assign data_index  = data_addr[$bits(mem_addr_t)-1:0];
    assign fetch_index = fetch_addr[$bits(mem_addr_t)-1:0];

    assign data_rdata = data_grant ? mem[data_index] : '0;
    assign fetch_inst = mem[fetch_index];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (data_grant && data_write) begin
            mem[data_index] <= data_wdata;
        end
    end

    // Loader and data access never compete, so no data access is dropped
    assert property (@(posedge clk) $onehot0({load_en, data_req}));

    assert property (@(posedge clk) data_req |-> !fetch_grant);

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      load_en,
    input  mem_addr_t load_addr,
    input  word_t     load_data,
    output word_t     output_port,
    output logic      output_valid,
    output word_t     num_inst,
    output logic      is_halted
);

    word_t fetch_addr;
    word_t fetch_inst;
    logic  fetch_grant;
    logic  data_req;
    logic  data_write;
    word_t data_addr;
    word_t data_wdata;
    word_t data_rdata;

    pipeline_core i_core (
        .clk          (clk),
        .reset_n      (reset_n),
        .fetch_addr   (fetch_addr),
        .fetch_inst   (fetch_inst),
        .fetch_grant  (fetch_grant),
        .data_req     (data_req),
        .data_write   (data_write),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    arbitrated_memory i_memory (
        .clk         (clk),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .data_req    (data_req),
        .data_write  (data_write),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_rdata  (data_rdata),
        .fetch_addr  (fetch_addr),
        .fetch_inst  (fetch_inst),
        .fetch_grant (fetch_grant)
    );

endmodule

// ==== dv/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu
    import cpu_pkg::*;
();

    localparam int NUM_PROGRAMS = 6;
    localparam int PROG_LEN     = 40;
    localparam int HALT_TIMEOUT = 2000;
    localparam int HALT_HOLD    = 20;

    logic      clk;
    logic      reset_n;
    logic      load_en;
    mem_addr_t load_addr;
    word_t     load_data;
    word_t     output_port;
    logic      output_valid;
    word_t     num_inst;
    logic      is_halted;

    logic [31:0] seed;
    int          errors;
    int          checks;
    int          model_count;
    logic        halted_ok;
    word_t       image [`CPU_MEM_DEPTH];
    word_t       expected_out [$];

    cpu_top i_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    always #10 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////

    function automatic int random_below(int n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return int'(seed[31:16]) % n;
    endfunction

    function automatic word_t encode_r(func_t fn, logic [1:0] rs, logic [1:0] rt, logic [1:0] rd);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic word_t encode_i(opcode_t op, logic [1:0] rs, logic [1:0] rt,
                                       logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic compare_values(string name, word_t expected, word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_outputs_cleared(string when);
        compare_values({"is_halted ", when}, 16'd0, word_t'(is_halted));
        compare_values({"output_valid ", when}, 16'd0, word_t'(output_valid));
        compare_values({"num_inst ", when}, 16'd0, num_inst);
    endtask

    ////////////////////
    // Program and model
    ////////////////////

    task automatic build_program();
        logic       landing_ok [PROG_LEN];
        logic       needs_target [PROG_LEN];
        int         i;
        int         kind;
        int         target;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        for (int a = 0; a < `CPU_MEM_DEPTH; a++) begin
            image[a] = word_t'(random_below(65536));
        end
        for (int k = 0; k < PROG_LEN; k++) begin
            landing_ok[k]   = 1'b1;
            needs_target[k] = 1'b0;
        end
        i = 0;
        while (i < PROG_LEN - 1) begin
            kind = random_below(16);
            rs   = 2'(random_below(4));
            rt   = 2'(random_below(4));
            rd   = 2'(random_below(4));
            if (kind >= 8 && kind <= 10 && i + 2 > PROG_LEN - 1) begin
                kind = 0;
            end
            case (kind)
                0, 1, 2, 3, 4: image[i] = encode_r(func_t'(6'(kind % 4)), rs, rt, rd);
                5, 6:          image[i] = encode_i(OP_ADI, rs, rt, 8'(random_below(256)));
                7, 14, 15:     image[i] = encode_r(FN_WWD, rs, 2'd0, 2'd0);
                8, 9, 10: begin
                    // Zeroed base, negative offset lands in 248..255
                    image[i]     = encode_r(FN_SUB, rs, rs, rs);
                    image[i + 1] = encode_i(kind == 10 ? OP_SWD : OP_LWD, rs, rt,
                                            8'hf8 | 8'(random_below(8)));
                    landing_ok[i + 1] = 1'b0;
                    i++;
                end
                11, 12: begin
                    image[i] = encode_i(kind == 11 ? OP_BNE : OP_BEQ, rs, rt, 8'h00);
                    needs_target[i] = 1'b1;
                end
                default: begin
                    image[i] = {OP_JMP, 12'h000};
                    needs_target[i] = 1'b1;
                end
            endcase
            i++;
        end
        image[PROG_LEN - 1] = encode_r(FN_HLT, 2'd0, 2'd0, 2'd0);
        // Forward targets only, never into the middle of a memory pair
        for (int k = 0; k < PROG_LEN - 1; k++) begin
            if (needs_target[k]) begin
                target = k + 1 + random_below(8);
                if (target > PROG_LEN - 1) begin
                    target = PROG_LEN - 1;
                end
                if (!landing_ok[target]) begin
                    target++;
                end
                if (image[k][15:12] == OP_JMP) begin
                    image[k][11:0] = 12'(target);
                end else begin
                    image[k][7:0] = 8'(target - k - 1);
                end
            end
        end
    endtask

    task automatic run_reference_model();
        word_t regs [`CPU_REG_COUNT];
        word_t mem [`CPU_MEM_DEPTH];
        word_t inst;
        word_t pc;
        word_t next_pc;
        word_t a;
        word_t b;
        word_t imm;
        word_t addr;
        logic  done;
        for (int k = 0; k < `CPU_MEM_DEPTH; k++) begin
            mem[k] = image[k];
        end
        for (int k = 0; k < `CPU_REG_COUNT; k++) begin
            regs[k] = '0;
        end
        expected_out.delete();
        model_count = 0;
        pc   = '0;
        done = 1'b0;
        while (!done && model_count < 1000) begin
            inst    = mem[pc[7:0]];
            a       = regs[inst[RS_MSB:RS_LSB]];
            b       = regs[inst[RT_MSB:RT_LSB]];
            imm     = {{8{inst[IMM_MSB]}}, inst[IMM_MSB:IMM_LSB]};
            addr    = a + imm;
            next_pc = pc + 16'd1;
            model_count++;
            case (opcode_t'(inst[OPCODE_MSB:OPCODE_LSB]))
                OP_RTYPE: begin
                    case (func_t'(inst[FUNC_MSB:FUNC_LSB]))
                        FN_ADD:  regs[inst[RD_MSB:RD_LSB]] = a + b;
                        FN_SUB:  regs[inst[RD_MSB:RD_LSB]] = a - b;
                        FN_AND:  regs[inst[RD_MSB:RD_LSB]] = a & b;
                        FN_ORR:  regs[inst[RD_MSB:RD_LSB]] = a | b;
                        FN_WWD:  expected_out.push_back(a);
                        FN_HLT:  done = 1'b1;
                        default: ;
                    endcase
                end
                OP_ADI:  regs[inst[RT_MSB:RT_LSB]] = addr;
                OP_LWD:  regs[inst[RT_MSB:RT_LSB]] = mem[addr[7:0]];
                OP_SWD:  mem[addr[7:0]] = b;
                OP_BNE:  next_pc = (a != b) ? next_pc + imm : next_pc;
                OP_BEQ:  next_pc = (a == b) ? next_pc + imm : next_pc;
                OP_JMP:  next_pc = {next_pc[15:12], inst[11:0]};
                default: ;
            endcase
            pc = next_pc;
        end
    endtask

    ////////////////////
    // DUT phases
    ////////////////////

    // Whole memory is written while reset is held
    task automatic load_and_reset();
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_outputs_cleared("in reset");
            end
            reset_n   = 1'b1;
            load_en   = 1'b1;
            load_addr = mem_addr_t'(i);
            load_data = image[i];
        end
        @(negedge clk);
        check_outputs_cleared("in reset");
        load_en = 1'b0;
        reset_n = 1'b0;
        @(negedge clk);
        check_outputs_cleared("after reset");
    endtask

    task automatic run_to_halt(int prog, output logic halted);
        int cycles;
        cycles = 0;
        while (!is_halted && cycles < HALT_TIMEOUT) begin
            if (output_valid) begin
                if (expected_out.size() == 0) begin
                    $display("Program %0d wrote an output the model never produced", prog);
                    errors++;
                end else begin
                    compare_values("output_port", expected_out.pop_front(), output_port);
                end
            end else begin
                compare_values("output_port idle", 16'd0, output_port);
            end
            @(negedge clk);
            cycles++;
        end
        halted = is_halted;
        if (!halted) begin
            $display("Program %0d did not halt within %0d cycles", prog, HALT_TIMEOUT);
            errors++;
        end else begin
            compare_values("outputs left over", 16'd0, word_t'(expected_out.size()));
            compare_values("num_inst at halt", word_t'(model_count), num_inst);
        end
    endtask

    task automatic check_after_halt();
        repeat (HALT_HOLD) begin
            @(negedge clk);
            compare_values("output_valid after halt", 16'd0, word_t'(output_valid));
            compare_values("num_inst after halt", word_t'(model_count), num_inst);
            compare_values("is_halted after halt", 16'd1, word_t'(is_halted));
        end
    endtask

    initial begin
        clk       = 1'b0;
        reset_n   = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed      = 32'h5d7eea4f;
        errors    = 0;
        checks    = 0;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            build_program();
            run_reference_model();
            load_and_reset();
            run_to_halt(p, halted_ok);
            if (halted_ok) begin
                check_after_halt();
            end
        end
        $display("Done: %0d programs, %0d checks, %0d errors", NUM_PROGRAMS, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+source
source/cpu_pkg.sv
source/control_decoder.sv
source/register_file.sv
source/hazard_unit.sv
source/pipeline_core.sv
source/arbitrated_memory.sv
source/cpu_top.sv
dv/tb_cpu.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f project.f --top-module tb_cpu -o tb_cpu

run: build
	./obj_dir/tb_cpu | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	verilator --lint-only --timing -f project.f --top-module tb_cpu

clean:
	rm -rf obj_dir $(LOG)
